// ==== verilog/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// bus widths
`define MEM_ADDR_WD 32
`define MEM_DATA_WD 32
`define MEM_STRB_WD (`MEM_DATA_WD / 8)

// sram window, only the low index bits reach the array
`define SRAM_BASE   32'h8000_0000
`define SRAM_SPAN   32'h0800_0000
`define SRAM_WORDS  256

// uart: +0 tx data, +4 byte count
`define UART_BASE   32'h1000_0000
// clint: +0 mtime low, +4 mtime high
`define CLINT_BASE  32'h0200_0000
`define DEV_SPAN    32'h0000_0010

`endif

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        READ_ADDR  = 3'd1,
        READ_DATA  = 3'd2,
        WRITE_ADDR = 3'd3,
        WRITE_RESP = 3'd4,
        ERR_RESP   = 3'd5
    } xbar_state_e;

    // value doubles as index into the slave vectors
    typedef enum logic [1:0] {
        SEL_SRAM  = 2'd0,
        SEL_UART  = 2'd1,
        SEL_CLINT = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

endpackage

// ==== verilog/axi_lite_if.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

interface axi_lite_if;

    logic [`MEM_ADDR_WD-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`MEM_DATA_WD-1:0] rdata;
    mem_pkg::axi_resp_e      rresp;
    logic                    rvalid;
    logic                    rready;

    logic [`MEM_ADDR_WD-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`MEM_DATA_WD-1:0] wdata;
    logic [`MEM_STRB_WD-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    mem_pkg::axi_resp_e      bresp;
    logic                    bvalid;
    logic                    bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

// ==== verilog/axi_crossbar.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module axi_crossbar (
    input  logic                    clock,
    input  logic                    rst,

    input  logic [`MEM_ADDR_WD-1:0] ifu_araddr,
    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    output logic [`MEM_DATA_WD-1:0] ifu_rdata,
    output logic [1:0]              ifu_rresp,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,

    input  logic [`MEM_ADDR_WD-1:0] lsu_araddr,
    input  logic                    lsu_arvalid,
    output logic                    lsu_arready,
    output logic [`MEM_DATA_WD-1:0] lsu_rdata,
    output logic [1:0]              lsu_rresp,
    output logic                    lsu_rvalid,
    input  logic                    lsu_rready,
    input  logic [`MEM_ADDR_WD-1:0] lsu_awaddr,
    input  logic                    lsu_awvalid,
    output logic                    lsu_awready,
    input  logic [`MEM_DATA_WD-1:0] lsu_wdata,
    input  logic [`MEM_STRB_WD-1:0] lsu_wstrb,
    input  logic                    lsu_wvalid,
    output logic                    lsu_wready,
    output logic [1:0]              lsu_bresp,
    output logic                    lsu_bvalid,
    input  logic                    lsu_bready,

    axi_lite_if.master              sram_bus,
    axi_lite_if.master              uart_bus,
    axi_lite_if.master              clint_bus
);

    mem_pkg::xbar_state_e    state, state_nxt;
    mem_pkg::slave_sel_e     sel_q, win_sel;
    logic                    lsu_q, write_q;
    logic [`MEM_ADDR_WD-1:0] addr_q, win_addr;
    logic [`MEM_DATA_WD-1:0] wdata_q;
    logic [`MEM_STRB_WD-1:0] wstrb_q;

    logic                    lsu_req, any_req, win_write, win_err, start, grant_lsu;
    logic                    idle_err, acc_rd, acc_wr;
    logic                    st_ar, st_r, st_aw, st_b, st_err;
    logic [3:0]              sel_hot;
    logic [3:0]              s_arready, s_rvalid, s_awready, s_wready, s_bvalid;
    logic [`MEM_DATA_WD-1:0] s_rdata [4];
    logic [1:0]              s_rresp [4];
    logic [1:0]              s_bresp [4];
    logic                    g_arready, g_wacc, g_rvalid, g_bvalid, g_rready;
    logic [`MEM_DATA_WD-1:0] g_rdata;
    logic [1:0]              g_rresp, g_bresp, err_resp;

    function automatic mem_pkg::slave_sel_e decode(input logic [`MEM_ADDR_WD-1:0] a);
        if (a >= `SRAM_BASE && a < `SRAM_BASE + `SRAM_SPAN)
            return mem_pkg::SEL_SRAM;
        if (a >= `UART_BASE && a < `UART_BASE + `DEV_SPAN)
            return mem_pkg::SEL_UART;
        if (a >= `CLINT_BASE && a < `CLINT_BASE + `DEV_SPAN)
            return mem_pkg::SEL_CLINT;
        return mem_pkg::SEL_NONE;
    endfunction

    // lsu has priority, and its write goes before its read
    assign lsu_req   = lsu_arvalid | (lsu_awvalid & lsu_wvalid);
    assign any_req   = lsu_req | ifu_arvalid;
    assign win_write = lsu_awvalid & lsu_wvalid;
    assign win_addr  = !lsu_req ? ifu_araddr : (win_write ? lsu_awaddr : lsu_araddr);
    assign win_sel   = decode(win_addr);
    assign win_err   = (win_sel == mem_pkg::SEL_NONE)
                     | (win_write & (win_sel == mem_pkg::SEL_CLINT));
    assign start     = (state == mem_pkg::IDLE) & any_req;
    assign grant_lsu = (state == mem_pkg::IDLE) ? lsu_req : lsu_q;

    assign st_ar   = (state == mem_pkg::READ_ADDR);
    assign st_r    = (state == mem_pkg::READ_DATA);
    assign st_aw   = (state == mem_pkg::WRITE_ADDR);
    assign st_b    = (state == mem_pkg::WRITE_RESP);
    assign st_err  = (state == mem_pkg::ERR_RESP);
    assign sel_hot = 4'b0001 << sel_q;

    // gather slave outputs, slot 3 stands for no slave
    assign s_arready = {1'b0, clint_bus.arready, uart_bus.arready, sram_bus.arready};
    assign s_rvalid  = {1'b0, clint_bus.rvalid,  uart_bus.rvalid,  sram_bus.rvalid};
    assign s_awready = {1'b0, clint_bus.awready, uart_bus.awready, sram_bus.awready};
    assign s_wready  = {1'b0, clint_bus.wready,  uart_bus.wready,  sram_bus.wready};
    assign s_bvalid  = {1'b0, clint_bus.bvalid,  uart_bus.bvalid,  sram_bus.bvalid};
    assign s_rdata   = '{sram_bus.rdata, uart_bus.rdata, clint_bus.rdata, '0};
    assign s_rresp   = '{sram_bus.rresp, uart_bus.rresp, clint_bus.rresp, 2'd0};
    assign s_bresp   = '{sram_bus.bresp, uart_bus.bresp, clint_bus.bresp, 2'd0};

    assign err_resp  = (sel_q == mem_pkg::SEL_NONE) ? mem_pkg::RESP_DECERR
                                                    : mem_pkg::RESP_SLVERR;
    assign g_arready = st_ar & s_arready[sel_q];
    assign g_wacc    = st_aw & s_awready[sel_q] & s_wready[sel_q];
    assign g_rvalid  = (st_r & s_rvalid[sel_q]) | (st_err & ~write_q);
    assign g_bvalid  = (st_b & s_bvalid[sel_q]) | (st_err & write_q);
    assign g_rdata   = st_r ? s_rdata[sel_q] : '0;
    assign g_rresp   = st_r ? s_rresp[sel_q] : err_resp;
    assign g_bresp   = st_b ? s_bresp[sel_q] : err_resp;
    assign g_rready  = lsu_q ? lsu_rready : ifu_rready;

    // error requests are taken straight from idle
    assign idle_err = start & win_err;
    assign acc_rd   = g_arready | (idle_err & ~win_write);
    assign acc_wr   = g_wacc | (idle_err & win_write);

    assign ifu_arready = ~grant_lsu & acc_rd;
    assign ifu_rvalid  = ~lsu_q & g_rvalid;
    assign ifu_rdata   = g_rdata;
    assign ifu_rresp   = g_rresp;
    assign lsu_arready = grant_lsu & acc_rd;
    assign lsu_rvalid  = lsu_q & g_rvalid;
    assign lsu_rdata   = g_rdata;
    assign lsu_rresp   = g_rresp;
    assign lsu_awready = acc_wr;
    assign lsu_wready  = acc_wr;
    assign lsu_bvalid  = g_bvalid;
    assign lsu_bresp   = g_bresp;

    assign sram_bus.araddr  = addr_q;
    assign sram_bus.arvalid = st_ar & sel_hot[0];
    assign sram_bus.rready  = st_r & sel_hot[0] & g_rready;
    assign sram_bus.awaddr  = addr_q;
    assign sram_bus.awvalid = st_aw & sel_hot[0];
    assign sram_bus.wdata   = wdata_q;
    assign sram_bus.wstrb   = wstrb_q;
    assign sram_bus.wvalid  = st_aw & sel_hot[0];
    assign sram_bus.bready  = st_b & sel_hot[0] & lsu_bready;

    assign uart_bus.araddr  = addr_q;
    assign uart_bus.arvalid = st_ar & sel_hot[1];
    assign uart_bus.rready  = st_r & sel_hot[1] & g_rready;
    assign uart_bus.awaddr  = addr_q;
    assign uart_bus.awvalid = st_aw & sel_hot[1];
    assign uart_bus.wdata   = wdata_q;
    assign uart_bus.wstrb   = wstrb_q;
    assign uart_bus.wvalid  = st_aw & sel_hot[1];
    assign uart_bus.bready  = st_b & sel_hot[1] & lsu_bready;

    // clint is read only
    assign clint_bus.araddr  = addr_q;
    assign clint_bus.arvalid = st_ar & sel_hot[2];
    assign clint_bus.rready  = st_r & sel_hot[2] & g_rready;
    assign clint_bus.awaddr  = '0;
    assign clint_bus.awvalid = 1'b0;
    assign clint_bus.wdata   = '0;
    assign clint_bus.wstrb   = '0;
    assign clint_bus.wvalid  = 1'b0;
    assign clint_bus.bready  = 1'b0;

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::IDLE: begin
                if (any_req)
                    state_nxt = win_err   ? mem_pkg::ERR_RESP :
                                win_write ? mem_pkg::WRITE_ADDR : mem_pkg::READ_ADDR;
            end
            mem_pkg::READ_ADDR:  if (g_arready) state_nxt = mem_pkg::READ_DATA;
            mem_pkg::READ_DATA:  if (g_rvalid & g_rready) state_nxt = mem_pkg::IDLE;
            mem_pkg::WRITE_ADDR: if (g_wacc) state_nxt = mem_pkg::WRITE_RESP;
            mem_pkg::WRITE_RESP: if (g_bvalid & lsu_bready) state_nxt = mem_pkg::IDLE;
            mem_pkg::ERR_RESP: begin
                if ((g_rvalid & g_rready) | (g_bvalid & lsu_bready))
                    state_nxt = mem_pkg::IDLE;
            end
            default: state_nxt = mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= mem_pkg::IDLE;
            sel_q   <= mem_pkg::SEL_NONE;
            lsu_q   <= 1'b0;
            write_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) begin
                sel_q   <= win_sel;
                lsu_q   <= lsu_req;
                write_q <= win_write;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            addr_q  <= win_addr;
            wdata_q <= lsu_wdata;
            wstrb_q <= lsu_wstrb;
        end
    end

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module axi_sram (
    input  logic       clock,
    input  logic       rst,
    axi_lite_if.slave  bus
);

    localparam int IDX_WD = $clog2(`SRAM_WORDS);

    logic [`MEM_DATA_WD-1:0] mem [`SRAM_WORDS];
    logic [`MEM_DATA_WD-1:0] rdata_q;
    logic                    rvalid_q;
    logic                    bvalid_q;
    logic                    rd_fire;
    logic                    wr_fire;
    logic [IDX_WD-1:0]       rd_idx;
    logic [IDX_WD-1:0]       wr_idx;

    // one outstanding response per channel
    assign bus.arready = ~rvalid_q;
    assign bus.awready = ~bvalid_q;
    assign bus.wready  = ~bvalid_q;

    assign rd_fire = bus.arvalid & ~rvalid_q;
    assign wr_fire = bus.awvalid & bus.wvalid & ~bvalid_q;

    // word index, upper address bits wrap
    assign rd_idx = bus.araddr[IDX_WD+1:2];
    assign wr_idx = bus.awaddr[IDX_WD+1:2];

    assign bus.rdata  = rdata_q;
    assign bus.rresp  = mem_pkg::RESP_OKAY;
    assign bus.rvalid = rvalid_q;
    assign bus.bresp  = mem_pkg::RESP_OKAY;
    assign bus.bvalid = bvalid_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (bus.rready)
                rvalid_q <= 1'b0;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (bus.bready)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire)
            rdata_q <= mem[rd_idx];
        if (wr_fire) begin
            for (int b = 0; b < `MEM_STRB_WD; b++) begin
                if (bus.wstrb[b])
                    mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

endmodule

// ==== verilog/axi_uart.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module axi_uart (
    input  logic       clock,
    input  logic       rst,
    axi_lite_if.slave  bus,
    output logic [7:0] uart_tx_data,
    output logic       uart_tx_valid
);

    logic [7:0]              tx_byte_q;
    logic [`MEM_DATA_WD-1:0] tx_count_q;
    logic [`MEM_DATA_WD-1:0] rdata_q;
    logic                    rvalid_q;
    logic                    bvalid_q;
    logic                    rd_fire;
    logic                    wr_fire;
    logic                    tx_write;

    assign bus.arready = ~rvalid_q;
    assign bus.awready = ~bvalid_q;
    assign bus.wready  = ~bvalid_q;

    assign rd_fire  = bus.arvalid & ~rvalid_q;
    assign wr_fire  = bus.awvalid & bus.wvalid & ~bvalid_q;
    // writes to other offsets are dropped
    assign tx_write = wr_fire & (bus.awaddr[3:2] == 2'd0);

    assign bus.rdata  = rdata_q;
    assign bus.rresp  = mem_pkg::RESP_OKAY;
    assign bus.rvalid = rvalid_q;
    assign bus.bresp  = mem_pkg::RESP_OKAY;
    assign bus.bvalid = bvalid_q;

    assign uart_tx_data = tx_byte_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            rvalid_q      <= 1'b0;
            bvalid_q      <= 1'b0;
            uart_tx_valid <= 1'b0;
            tx_byte_q     <= 8'd0;
            tx_count_q    <= '0;
        end else begin
            uart_tx_valid <= tx_write;
            if (tx_write) begin
                tx_byte_q  <= bus.wdata[7:0];
                tx_count_q <= tx_count_q + 1'b1;
            end
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (bus.rready)
                rvalid_q <= 1'b0;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (bus.bready)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire) begin
            case (bus.araddr[3:2])
                2'd0:    rdata_q <= {{(`MEM_DATA_WD-8){1'b0}}, tx_byte_q};
                2'd1:    rdata_q <= tx_count_q;
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/axi_clint.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module axi_clint (
    input  logic       clock,
    input  logic       rst,
    axi_lite_if.slave  bus
);

    logic [63:0]             mtime_q;
    logic [`MEM_DATA_WD-1:0] rdata_q;
    logic                    rvalid_q;
    logic                    rd_fire;

    assign bus.arready = ~rvalid_q;
    assign rd_fire     = bus.arvalid & ~rvalid_q;

    assign bus.rdata  = rdata_q;
    assign bus.rresp  = mem_pkg::RESP_OKAY;
    assign bus.rvalid = rvalid_q;

    // no write path
    assign bus.awready = 1'b0;
    assign bus.wready  = 1'b0;
    assign bus.bvalid  = 1'b0;
    assign bus.bresp   = mem_pkg::RESP_SLVERR;

    always_ff @(posedge clock) begin
        if (rst) begin
            mtime_q  <= 64'd0;
            rvalid_q <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (bus.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire)
            rdata_q <= bus.araddr[2] ? mtime_q[63:32] : mtime_q[31:0];
    end

endmodule

// ==== verilog/mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys (
    input  logic                    clock,
    input  logic                    rst,

    input  logic [`MEM_ADDR_WD-1:0] ifu_araddr,
    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    output logic [`MEM_DATA_WD-1:0] ifu_rdata,
    output logic [1:0]              ifu_rresp,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,

    input  logic [`MEM_ADDR_WD-1:0] lsu_araddr,
    input  logic                    lsu_arvalid,
    output logic                    lsu_arready,
    output logic [`MEM_DATA_WD-1:0] lsu_rdata,
    output logic [1:0]              lsu_rresp,
    output logic                    lsu_rvalid,
    input  logic                    lsu_rready,
    input  logic [`MEM_ADDR_WD-1:0] lsu_awaddr,
    input  logic                    lsu_awvalid,
    output logic                    lsu_awready,
    input  logic [`MEM_DATA_WD-1:0] lsu_wdata,
    input  logic [`MEM_STRB_WD-1:0] lsu_wstrb,
    input  logic                    lsu_wvalid,
    output logic                    lsu_wready,
    output logic [1:0]              lsu_bresp,
    output logic                    lsu_bvalid,
    input  logic                    lsu_bready,

    output logic [7:0]              uart_tx_data,
    output logic                    uart_tx_valid
);

    axi_lite_if sram_bus ();
    axi_lite_if uart_bus ();
    axi_lite_if clint_bus ();

    // master ports and the three slave links match by name
    axi_crossbar u_axi_crossbar (.*);

    axi_sram u_sram (
        .clock (clock   ),
        .rst   (rst     ),
        .bus   (sram_bus)
    );

    axi_uart u_uart (
        .clock         (clock        ),
        .rst           (rst          ),
        .bus           (uart_bus     ),
        .uart_tx_data  (uart_tx_data ),
        .uart_tx_valid (uart_tx_valid)
    );

    axi_clint u_clint (
        .clock (clock    ),
        .rst   (rst      ),
        .bus   (clint_bus)
    );

endmodule

// ==== dv/mem_subsys_assert.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_assert (
    input logic                    clock,
    input logic                    rst,
    input logic                    ifu_rvalid,
    input logic                    ifu_rready,
    input logic [`MEM_DATA_WD-1:0] ifu_rdata,
    input logic [1:0]              ifu_rresp,
    input logic                    lsu_rvalid,
    input logic                    lsu_rready,
    input logic [`MEM_DATA_WD-1:0] lsu_rdata,
    input logic [1:0]              lsu_rresp,
    input logic                    lsu_bvalid,
    input logic                    lsu_bready,
    input logic [1:0]              lsu_bresp,
    input logic                    uart_tx_valid
);

    // responses hold until the master takes them
    ifu_r_held: assert property (@(posedge clock) disable iff (rst)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp))
        else $error("ifu read response changed while rready was low");

    lsu_r_held: assert property (@(posedge clock) disable iff (rst)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
        else $error("lsu read response changed while rready was low");

    lsu_b_held: assert property (@(posedge clock) disable iff (rst)
        lsu_bvalid && !lsu_bready |=> lsu_bvalid && $stable(lsu_bresp))
        else $error("lsu write response changed while bready was low");

    valid_low_in_reset: assert property (@(posedge clock)
        rst |=> !ifu_rvalid && !lsu_rvalid && !lsu_bvalid && !uart_tx_valid)
        else $error("valid output high right after reset");

    tx_single_pulse: assert property (@(posedge clock) disable iff (rst)
        uart_tx_valid |=> !uart_tx_valid)
        else $error("uart_tx_valid high for two cycles");

endmodule

bind mem_subsys mem_subsys_assert u_mem_subsys_assert (.*);

// ==== dv/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_tb;

    localparam int NUM_OPS  = 20;
    localparam int NUM_RAND = 16;
    // table, random loop and a handful of directed transfers
    localparam int WATCHDOG_CYCLES = 200 * (NUM_OPS + 2 * NUM_RAND + 8);

    typedef struct packed {
        logic        lsu;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic [31:0] exp_mask;
        logic [1:0]  exp_resp;
    } op_t;

    // lsu, wr, addr, wdata, strb, exp_data, exp_mask, exp_resp
    localparam op_t OPS [NUM_OPS] = '{
        '{1'b1, 1'b1, `SRAM_BASE,           32'h1122_3344, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `SRAM_BASE + 32'h4,   32'hcafe_f00d, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, `SRAM_BASE,           32'h0, 4'h0, 32'h1122_3344, '1, mem_pkg::RESP_OKAY},
        '{1'b0, 1'b0, `SRAM_BASE + 32'h4,   32'h0, 4'h0, 32'hcafe_f00d, '1, mem_pkg::RESP_OKAY},
        // bytes 0 and 2 replaced, then byte 3
        '{1'b1, 1'b1, `SRAM_BASE,           32'haabb_ccdd, 4'h5, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, `SRAM_BASE,           32'h0, 4'h0, 32'h11bb_33dd, '1, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `SRAM_BASE,           32'hee00_0000, 4'h8, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, `SRAM_BASE,           32'h0, 4'h0, 32'heebb_33dd, '1, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `UART_BASE,           32'h0000_0141, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `UART_BASE,           32'h0000_0042, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, `UART_BASE + 32'h4,   32'h0, 4'h0, 32'h0000_0002, '1, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, `UART_BASE,           32'h0, 4'h0, 32'h0000_0042, '1, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b0, 32'h4000_0000,        32'h0, 4'h0, 32'h0, '1, mem_pkg::RESP_DECERR},
        '{1'b0, 1'b0, 32'h0000_1000,        32'h0, 4'h0, 32'h0, '1, mem_pkg::RESP_DECERR},
        '{1'b1, 1'b1, 32'h4000_0000,        32'h1, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_DECERR},
        '{1'b1, 1'b1, `CLINT_BASE,          32'h1, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_SLVERR},
        '{1'b1, 1'b0, `CLINT_BASE + 32'h4,  32'h0, 4'h0, 32'h0, '1, mem_pkg::RESP_OKAY},
        // mtime low keeps moving so only the response is checked
        '{1'b1, 1'b0, `CLINT_BASE,          32'h0, 4'h0, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `SRAM_BASE + 32'h40,  32'h0000_0013, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY},
        '{1'b1, 1'b1, `SRAM_BASE + 32'h44,  32'h0010_0093, 4'hf, 32'h0, 32'h0, mem_pkg::RESP_OKAY}
    };

    logic                    clock = 1'b0;
    logic                    rst;
    logic [`MEM_ADDR_WD-1:0] ifu_araddr, lsu_araddr, lsu_awaddr;
    logic [`MEM_DATA_WD-1:0] ifu_rdata, lsu_rdata, lsu_wdata;
    logic [`MEM_STRB_WD-1:0] lsu_wstrb;
    logic [1:0]              ifu_rresp, lsu_rresp, lsu_bresp;
    logic                    ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic                    lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic                    lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
    logic                    lsu_bvalid, lsu_bready;
    logic [7:0]              uart_tx_data;
    logic                    uart_tx_valid;

    logic [31:0] rng = 32'h5f78;
    logic [31:0] model [`SRAM_WORDS];
    int          rand_idx [NUM_RAND];
    logic [7:0]  tx_exp [$];
    logic [7:0]  tx_seen [$];
    logic [31:0] data, t_first, t_second;
    logic [1:0]  resp, wresp;
    int          k, idx;

    mem_subsys u_mem_subsys (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (!rst && uart_tx_valid)
            tx_seen.push_back(uart_tx_data);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic set_rready(input logic lsu, input logic v);
        if (lsu)
            lsu_rready <= v;
        else
            ifu_rready <= v;
    endtask

    // hold > 0 keeps rready low for that many cycles after rvalid
    task automatic bus_read(input logic lsu, input logic [31:0] addr, input int hold,
                            output logic [31:0] rd, output logic [1:0] rr);
        int i;
        @(posedge clock);
        if (lsu) begin
            lsu_araddr  <= addr;
            lsu_arvalid <= 1'b1;
        end else begin
            ifu_araddr  <= addr;
            ifu_arvalid <= 1'b1;
        end
        do
            @(posedge clock);
        while (!(lsu ? lsu_arready : ifu_arready));
        if (lsu)
            lsu_arvalid <= 1'b0;
        else
            ifu_arvalid <= 1'b0;
        set_rready(lsu, hold == 0);
        do
            @(posedge clock);
        while (!(lsu ? lsu_rvalid : ifu_rvalid));
        rd = lsu ? lsu_rdata : ifu_rdata;
        rr = lsu ? lsu_rresp : ifu_rresp;
        if (hold > 0) begin
            for (i = 0; i <= hold; i++) begin
                if (i == hold)
                    set_rready(lsu, 1'b1);
                @(posedge clock);
                check_val("rvalid while held", lsu ? lsu_rvalid : ifu_rvalid, 1);
                check_val("rdata while held", lsu ? lsu_rdata : ifu_rdata, rd);
                check_val("rresp while held", lsu ? lsu_rresp : ifu_rresp, rr);
            end
        end
        set_rready(lsu, 1'b0);
    endtask

    // aw and w go out together and bready waits hold cycles after bvalid
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wd,
                             input logic [3:0] strb, input int hold,
                             output logic [1:0] br);
        int i;
        @(posedge clock);
        lsu_awaddr  <= addr;
        lsu_awvalid <= 1'b1;
        lsu_wdata   <= wd;
        lsu_wstrb   <= strb;
        lsu_wvalid  <= 1'b1;
        lsu_bready  <= (hold == 0);
        do
            @(posedge clock);
        while (!(lsu_awready && lsu_wready));
        lsu_awvalid <= 1'b0;
        lsu_wvalid  <= 1'b0;
        do
            @(posedge clock);
        while (!lsu_bvalid);
        br = lsu_bresp;
        if (hold > 0) begin
            for (i = 0; i <= hold; i++) begin
                if (i == hold)
                    lsu_bready <= 1'b1;
                @(posedge clock);
                check_val("lsu_bvalid while held", lsu_bvalid, 1);
                check_val("lsu_bresp while held", lsu_bresp, br);
            end
        end
        lsu_bready <= 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: transfers did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst         = 1'b1;
        ifu_araddr  = '0;
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b0;
        lsu_araddr  = '0;
        lsu_arvalid = 1'b0;
        lsu_rready  = 1'b0;
        lsu_awaddr  = '0;
        lsu_awvalid = 1'b0;
        lsu_wdata   = '0;
        lsu_wstrb   = '0;
        lsu_wvalid  = 1'b0;
        lsu_bready  = 1'b0;
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        for (k = 0; k < NUM_OPS; k++) begin
            if (OPS[k].wr) begin
                bus_write(OPS[k].addr, OPS[k].wdata, OPS[k].strb, 0, resp);
                if (OPS[k].addr == `UART_BASE && OPS[k].exp_resp == mem_pkg::RESP_OKAY)
                    tx_exp.push_back(OPS[k].wdata[7:0]);
            end else begin
                bus_read(OPS[k].lsu, OPS[k].addr, 0, data, resp);
                check_val($sformatf("rdata op %0d", k), data & OPS[k].exp_mask,
                          OPS[k].exp_data);
            end
            check_val($sformatf("resp op %0d", k), resp, OPS[k].exp_resp);
        end
        check_val("uart_tx_valid pulses", tx_seen.size(), tx_exp.size());
        foreach (tx_exp[i])
            check_val("uart_tx_data", tx_seen[i], tx_exp[i]);

        // mtime low must move forward
        bus_read(1'b1, `CLINT_BASE, 0, t_first, resp);
        bus_read(1'b1, `CLINT_BASE, 0, t_second, resp);
        check_val("mtime low increase", t_second > t_first, 1);

        // random words in the upper half of the sram away from the table words
        for (k = 0; k < NUM_RAND; k++) begin
            rng = lcg_next(rng);
            idx = 128 + int'(rng[22:16]);
            rng = lcg_next(rng);
            model[idx]  = rng;
            rand_idx[k] = idx;
            bus_write(`SRAM_BASE + 32'(4 * idx), rng, 4'hf, k % 4, resp);
            check_val("lsu_bresp", resp, mem_pkg::RESP_OKAY);
        end
        for (k = 0; k < NUM_RAND; k++) begin
            bus_read(1'b1, `SRAM_BASE + 32'(4 * rand_idx[k]), k % 3, data, resp);
            check_val("lsu_rdata", data, model[rand_idx[k]]);
            check_val("lsu_rresp", resp, mem_pkg::RESP_OKAY);
        end

        // ifu fetch and lsu store raised in the same cycle
        fork
            bus_read(1'b0, `SRAM_BASE + 32'h40, 4, data, resp);
            bus_write(`SRAM_BASE + 32'h80, 32'h0bad_cafe, 4'hf, 0, wresp);
        join
        check_val("ifu_rdata", data, 32'h0000_0013);
        check_val("ifu_rresp", resp, mem_pkg::RESP_OKAY);
        check_val("lsu_bresp", wresp, mem_pkg::RESP_OKAY);
        bus_read(1'b1, `SRAM_BASE + 32'h80, 0, data, resp);
        check_val("lsu_rdata", data, 32'h0bad_cafe);
        bus_read(1'b0, `SRAM_BASE + 32'h44, 0, data, resp);
        check_val("ifu_rdata", data, 32'h0010_0093);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/axi_lite_if.sv
verilog/axi_crossbar.sv
verilog/axi_sram.sv
verilog/axi_uart.sv
verilog/axi_clint.sv
verilog/mem_subsys.sv
dv/mem_subsys_assert.sv
dv/mem_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
